//--- design/pipePkg.sv
package pipePkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regAddrT;

    // unified memory, word addressed
    localparam int MEM_WORDS = 256;
    typedef logic [7:0] memAddrT;

    localparam int PC_STEP = 4;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // function code of opSpecial, instr[5:0]
    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOpT;

    // operand source for execute
    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdWb   = 2'd1,
        fwdMem  = 2'd2
    } fwdSelT;

endpackage

//--- design/unifiedMemory.sv
module unifiedMemory import pipePkg::*; (
    input  logic    clk,
    input  memAddrT addr_i,
    input  logic    wrEn_i,
    input  wordT    wrData_i,
    output wordT    rdData_o
);

    wordT mem [MEM_WORDS];

    // write lands at the edge, read sees the array directly
    always_ff @(posedge clk) begin
        if (wrEn_i) begin
            mem[addr_i] <= wrData_i;
        end
    end

    assign rdData_o = mem[addr_i];

endmodule

//--- design/memArbiter.sv
module memArbiter import pipePkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    loadEn_i,
    input  memAddrT loadAddr_i,
    input  wordT    loadData_i,
    input  logic    memReq_i,
    input  logic    memWrEn_i,
    input  memAddrT memAddr_i,
    input  wordT    memWrData_i,
    input  logic    fetchReq_i,
    input  memAddrT fetchAddr_i,
    output logic    loadGnt_o,
    output logic    memGnt_o,
    output logic    fetchGnt_o,
    output memAddrT addr_o,
    output logic    wrEn_o,
    output wordT    wrData_o
);

    logic armed;

    // core requesters stay masked until reset has been seen
    always_ff @(posedge clk) begin
        if (reset_i) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

    // loader, then data, then fetch
    assign loadGnt_o  = loadEn_i && !reset_i;
    assign memGnt_o   = armed && memReq_i && !loadEn_i;
    assign fetchGnt_o = armed && fetchReq_i && !loadEn_i && !memReq_i;

    always_comb begin
        addr_o   = fetchAddr_i;
        wrEn_o   = 1'b0;
        wrData_o = memWrData_i;
        if (loadGnt_o) begin
            addr_o   = loadAddr_i;
            wrEn_o   = 1'b1;
            wrData_o = loadData_i;
        end else if (memGnt_o) begin
            addr_o = memAddr_i;
            wrEn_o = memWrEn_i;
        end
    end

endmodule

//--- design/fetchStage.sv
module fetchStage import pipePkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       stallF_i,
    input  logic       stallD_i,
    input  logic [1:0] pcSrcD_i,
    input  wordT       branchTargetD_i,
    input  wordT       jumpTargetD_i,
    input  logic       fetchGnt_i,
    input  wordT       instrIn_i,
    output logic       fetchReq_o,
    output memAddrT    fetchAddr_o,
    output wordT       instrD_o,
    output wordT       pcPlus4D_o,
    output wordT       pcD_o
);

    wordT pc;
    wordT pcPlus4F;
    wordT pcNext;
    logic fetchEn;

    assign pcPlus4F = pc + PC_STEP;

    // 1 is a taken beq, 2 is j
    always_comb begin
        case (pcSrcD_i)
            2'd1:    pcNext = branchTargetD_i;
            2'd2:    pcNext = jumpTargetD_i;
            default: pcNext = pcPlus4F;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc      <= '0;
            fetchEn <= 1'b0;
        end else begin
            fetchEn <= 1'b1;
            if (!stallF_i) begin
                pc <= pcNext;
            end
        end
    end

    assign fetchReq_o  = fetchEn;
    assign fetchAddr_o = pc[9:2];

    // fetch/decode register, an all-zero word decodes as a no-op
    always_ff @(posedge clk) begin
        if (reset_i) begin
            instrD_o <= '0;
        end else if (!stallD_i && fetchGnt_i) begin
            instrD_o <= instrIn_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD_o      <= pc;
            pcPlus4D_o <= pcPlus4F;
        end
    end

endmodule

//--- design/decodeStage.sv
module decodeStage import pipePkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  wordT       instrD_i,
    input  wordT       pcPlus4D_i,
    input  wordT       pcD_i,
    input  logic       flushE_i,
    input  logic       stallE_i,
    input  logic       fwdBranchA_i,
    input  logic       fwdBranchB_i,
    input  wordT       aluOutM_i,
    input  logic       regWriteEnW_i,
    input  regAddrT    writeRegW_i,
    input  wordT       regWriteDataW_i,
    output logic [1:0] pcSrcD_o,
    output wordT       branchTargetD_o,
    output wordT       jumpTargetD_o,
    output regAddrT    rsD_o,
    output regAddrT    rtD_o,
    output logic       branchD_o,
    output regAddrT    rsE_o,
    output regAddrT    rtE_o,
    output wordT       rd1E_o,
    output wordT       rd2E_o,
    output wordT       immE_o,
    output regAddrT    writeRegE_o,
    output aluOpT      aluOpE_o,
    output logic       aluSrcImmE_o,
    output logic       regWriteEnE_o,
    output logic       memReadE_o,
    output logic       memWriteE_o,
    output wordT       pcE_o
);

    wordT    regs [32];
    wordT    rd1D;
    wordT    rd2D;
    wordT    immD;
    wordT    cmpA;
    wordT    cmpB;
    regAddrT writeRegD;
    aluOpT   aluOpD;
    logic    aluSrcImmD;
    logic    regWriteD;
    logic    memReadD;
    logic    memWriteD;
    logic    jumpD;
    logic    zeroExtD;
    logic    useRdD;

    assign rsD_o = instrD_i[25:21];
    assign rtD_o = instrD_i[20:16];

    // register file, written from W
    always_ff @(posedge clk) begin
        if (regWriteEnW_i) begin
            regs[writeRegW_i] <= regWriteDataW_i;
        end
    end

    // same-cycle write is visible to the read
    always_comb begin
        rd1D = regs[rsD_o];
        rd2D = regs[rtD_o];
        if (regWriteEnW_i && writeRegW_i == rsD_o) begin
            rd1D = regWriteDataW_i;
        end
        if (regWriteEnW_i && writeRegW_i == rtD_o) begin
            rd2D = regWriteDataW_i;
        end
        if (rsD_o == '0) begin
            rd1D = '0;
        end
        if (rtD_o == '0) begin
            rd2D = '0;
        end
    end

    // main decoder, anything unknown stays a no-op
    always_comb begin
        aluOpD     = aluAdd;
        aluSrcImmD = 1'b1;
        regWriteD  = 1'b0;
        memReadD   = 1'b0;
        memWriteD  = 1'b0;
        branchD_o  = 1'b0;
        jumpD      = 1'b0;
        zeroExtD   = 1'b0;
        useRdD     = 1'b0;
        case (instrD_i[31:26])
            opSpecial: begin
                aluSrcImmD = 1'b0;
                useRdD     = 1'b1;
                regWriteD  = 1'b1;
                case (instrD_i[5:0])
                    fnAddu:  aluOpD = aluAdd;
                    fnSubu:  aluOpD = aluSub;
                    fnAnd:   aluOpD = aluAnd;
                    fnOr:    aluOpD = aluOr;
                    fnSlt:   aluOpD = aluSlt;
                    default: regWriteD = 1'b0;
                endcase
            end
            opAddiu: regWriteD = 1'b1;
            opOri: begin
                regWriteD = 1'b1;
                aluOpD    = aluOr;
                zeroExtD  = 1'b1;
            end
            opLui: begin
                regWriteD = 1'b1;
                aluOpD    = aluLui;
            end
            opLw: begin
                regWriteD = 1'b1;
                memReadD  = 1'b1;
            end
            opSw:    memWriteD = 1'b1;
            opBeq:   branchD_o = 1'b1;
            opJ:     jumpD = 1'b1;
            default: regWriteD = 1'b0;
        endcase
    end

    assign writeRegD = useRdD ? instrD_i[15:11] : rtD_o;
    assign immD = zeroExtD ? {16'b0, instrD_i[15:0]} : {{16{instrD_i[15]}}, instrD_i[15:0]};

    // beq resolves here, with operands taken from M when needed
    assign cmpA = fwdBranchA_i ? aluOutM_i : rd1D;
    assign cmpB = fwdBranchB_i ? aluOutM_i : rd2D;

    assign branchTargetD_o = pcPlus4D_i + {immD[29:0], 2'b00};
    assign jumpTargetD_o   = {pcPlus4D_i[31:28], instrD_i[25:0], 2'b00};
    assign pcSrcD_o = jumpD ? 2'd2 : (branchD_o && cmpA == cmpB) ? 2'd1 : 2'd0;

    // decode/execute register, writes to r0 are dropped here
    always_ff @(posedge clk) begin
        if (reset_i || flushE_i) begin
            regWriteEnE_o <= 1'b0;
            memReadE_o    <= 1'b0;
            memWriteE_o   <= 1'b0;
        end else if (!stallE_i) begin
            regWriteEnE_o <= regWriteD && writeRegD != '0;
            memReadE_o    <= memReadD;
            memWriteE_o   <= memWriteD;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallE_i) begin
            rsE_o        <= rsD_o;
            rtE_o        <= rtD_o;
            rd1E_o       <= rd1D;
            rd2E_o       <= rd2D;
            immE_o       <= immD;
            writeRegE_o  <= writeRegD;
            aluOpE_o     <= aluOpD;
            aluSrcImmE_o <= aluSrcImmD;
            pcE_o        <= pcD_i;
        end
    end

endmodule

//--- design/execMemWbStages.sv
module execMemWbStages import pipePkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  wordT    rd1E_i,
    input  wordT    rd2E_i,
    input  wordT    immE_i,
    input  regAddrT writeRegE_i,
    input  aluOpT   aluOpE_i,
    input  logic    aluSrcImmE_i,
    input  logic    regWriteEnE_i,
    input  logic    memReadE_i,
    input  logic    memWriteE_i,
    input  wordT    pcE_i,
    input  fwdSelT  fwdA_i,
    input  fwdSelT  fwdB_i,
    input  logic    stallM_i,
    input  logic    memGnt_i,
    input  wordT    memRdData_i,
    output logic    memReq_o,
    output logic    memWrEn_o,
    output memAddrT memAddr_o,
    output wordT    memWrData_o,
    output wordT    aluOutM_o,
    output regAddrT writeRegM_o,
    output logic    regWriteEnM_o,
    output logic    memReadM_o,
    output regAddrT writeRegW_o,
    output logic    regWriteEnW_o,
    output wordT    regWriteDataW_o,
    output wordT    pcW_o
);

    wordT srcA;
    wordT srcB;
    wordT aluB;
    wordT aluOutE;
    wordT writeDataM;
    wordT pcM;
    logic memWriteM;
    wordT aluOutW;
    wordT readDataW;
    logic memReadW;

    // M result wins over W
    always_comb begin
        case (fwdA_i)
            fwdMem:  srcA = aluOutM_o;
            fwdWb:   srcA = regWriteDataW_o;
            default: srcA = rd1E_i;
        endcase
        case (fwdB_i)
            fwdMem:  srcB = aluOutM_o;
            fwdWb:   srcB = regWriteDataW_o;
            default: srcB = rd2E_i;
        endcase
    end

    assign aluB = aluSrcImmE_i ? immE_i : srcB;

    always_comb begin
        case (aluOpE_i)
            aluSub:  aluOutE = srcA - aluB;
            aluAnd:  aluOutE = srcA & aluB;
            aluOr:   aluOutE = srcA | aluB;
            aluSlt:  aluOutE = {31'b0, $signed(srcA) < $signed(aluB)};
            aluLui:  aluOutE = {aluB[15:0], 16'b0};
            default: aluOutE = srcA + aluB;
        endcase
    end

    // execute/memory register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            regWriteEnM_o <= 1'b0;
            memReadM_o    <= 1'b0;
            memWriteM     <= 1'b0;
        end else if (!stallM_i) begin
            regWriteEnM_o <= regWriteEnE_i;
            memReadM_o    <= memReadE_i;
            memWriteM     <= memWriteE_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallM_i) begin
            aluOutM_o   <= aluOutE;
            writeDataM  <= srcB;
            writeRegM_o <= writeRegE_i;
            pcM         <= pcE_i;
        end
    end

    // word access only
    assign memReq_o    = memReadM_o || memWriteM;
    assign memWrEn_o   = memWriteM;
    assign memAddr_o   = aluOutM_o[9:2];
    assign memWrData_o = writeDataM;

    // a held M sends a bubble on, so nothing retires twice
    always_ff @(posedge clk) begin
        if (reset_i || stallM_i) begin
            regWriteEnW_o <= 1'b0;
            memReadW      <= 1'b0;
        end else begin
            regWriteEnW_o <= regWriteEnM_o;
            memReadW      <= memReadM_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallM_i) begin
            aluOutW     <= aluOutM_o;
            writeRegW_o <= writeRegM_o;
            pcW_o       <= pcM;
        end
        if (memGnt_i) begin
            readDataW <= memRdData_i;
        end
    end

    assign regWriteDataW_o = memReadW ? readDataW : aluOutW;

endmodule

//--- design/hazardUnit.sv
module hazardUnit import pipePkg::*; (
    input  regAddrT rsD_i,
    input  regAddrT rtD_i,
    input  regAddrT rsE_i,
    input  regAddrT rtE_i,
    input  regAddrT writeRegE_i,
    input  regAddrT writeRegM_i,
    input  regAddrT writeRegW_i,
    input  logic    regWriteEnE_i,
    input  logic    regWriteEnM_i,
    input  logic    regWriteEnW_i,
    input  logic    memReadE_i,
    input  logic    memReadM_i,
    input  logic    branchD_i,
    input  logic    fetchGnt_i,
    input  logic    loadGnt_i,
    output fwdSelT  fwdA_o,
    output fwdSelT  fwdB_o,
    output logic    fwdBranchA_o,
    output logic    fwdBranchB_o,
    output logic    stallF_o,
    output logic    stallD_o,
    output logic    stallE_o,
    output logic    stallM_o,
    output logic    flushE_o
);

    logic hitE;
    logic hitM;
    logic loadUse;
    logic branchWait;

    // the write enables never carry r0, so no zero checks
    assign fwdA_o = (regWriteEnM_i && writeRegM_i == rsE_i) ? fwdMem :
                    (regWriteEnW_i && writeRegW_i == rsE_i) ? fwdWb : fwdNone;
    assign fwdB_o = (regWriteEnM_i && writeRegM_i == rtE_i) ? fwdMem :
                    (regWriteEnW_i && writeRegW_i == rtE_i) ? fwdWb : fwdNone;

    assign fwdBranchA_o = regWriteEnM_i && writeRegM_i == rsD_i;
    assign fwdBranchB_o = regWriteEnM_i && writeRegM_i == rtD_i;

    assign hitE = regWriteEnE_i && (writeRegE_i == rsD_i || writeRegE_i == rtD_i);
    assign hitM = regWriteEnM_i && (writeRegM_i == rsD_i || writeRegM_i == rtD_i);

    assign loadUse    = memReadE_i && hitE;
    // beq waits until its operand is an ALU result in M
    assign branchWait = branchD_i && (hitE || (memReadM_i && hitM));

    // loader grant freezes the whole pipe
    assign stallE_o = loadGnt_i;
    assign stallM_o = loadGnt_i;
    assign stallF_o = loadUse || branchWait || !fetchGnt_i;
    assign stallD_o = stallF_o;
    assign flushE_o = !loadGnt_i && stallD_o;

endmodule

//--- design/mipsCore.sv
module mipsCore import pipePkg::*; (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    loadEn_i,
    input  memAddrT loadAddr_i,
    input  wordT    loadData_i,
    output wordT    pcW_o,
    output logic    regWriteEnW_o,
    output regAddrT writeRegW_o,
    output wordT    regWriteDataW_o
);

    // fetch and decode
    logic [1:0] pcSrcD;
    wordT       branchTargetD;
    wordT       jumpTargetD;
    wordT       instrD;
    wordT       pcPlus4D;
    wordT       pcD;
    regAddrT    rsD;
    regAddrT    rtD;
    logic       branchD;

    // execute
    regAddrT rsE;
    regAddrT rtE;
    wordT    rd1E;
    wordT    rd2E;
    wordT    immE;
    regAddrT writeRegE;
    aluOpT   aluOpE;
    logic    aluSrcImmE;
    logic    regWriteEnE;
    logic    memReadE;
    logic    memWriteE;
    wordT    pcE;

    // memory stage
    wordT    aluOutM;
    regAddrT writeRegM;
    logic    regWriteEnM;
    logic    memReadM;

    // hazard controls
    fwdSelT fwdA;
    fwdSelT fwdB;
    logic   fwdBranchA;
    logic   fwdBranchB;
    logic   stallF;
    logic   stallD;
    logic   stallE;
    logic   stallM;
    logic   flushE;

    // shared memory port
    logic    fetchReq;
    memAddrT fetchAddr;
    logic    memReq;
    logic    memWrEn;
    memAddrT memAddr;
    wordT    memWrData;
    logic    loadGnt;
    logic    memGnt;
    logic    fetchGnt;
    memAddrT portAddr;
    logic    portWrEn;
    wordT    portWrData;
    wordT    portRdData;

    fetchStage fetch0 (
        .clk(clk), .reset_i(reset_i), .stallF_i(stallF), .stallD_i(stallD),
        .pcSrcD_i(pcSrcD), .branchTargetD_i(branchTargetD), .jumpTargetD_i(jumpTargetD),
        .fetchGnt_i(fetchGnt), .instrIn_i(portRdData), .fetchReq_o(fetchReq),
        .fetchAddr_o(fetchAddr), .instrD_o(instrD), .pcPlus4D_o(pcPlus4D), .pcD_o(pcD)
    );

    decodeStage decode0 (
        .clk(clk), .reset_i(reset_i), .instrD_i(instrD), .pcPlus4D_i(pcPlus4D),
        .pcD_i(pcD), .flushE_i(flushE), .stallE_i(stallE),
        .fwdBranchA_i(fwdBranchA), .fwdBranchB_i(fwdBranchB), .aluOutM_i(aluOutM),
        .regWriteEnW_i(regWriteEnW_o), .writeRegW_i(writeRegW_o),
        .regWriteDataW_i(regWriteDataW_o), .pcSrcD_o(pcSrcD),
        .branchTargetD_o(branchTargetD), .jumpTargetD_o(jumpTargetD),
        .rsD_o(rsD), .rtD_o(rtD), .branchD_o(branchD), .rsE_o(rsE), .rtE_o(rtE),
        .rd1E_o(rd1E), .rd2E_o(rd2E), .immE_o(immE), .writeRegE_o(writeRegE),
        .aluOpE_o(aluOpE), .aluSrcImmE_o(aluSrcImmE), .regWriteEnE_o(regWriteEnE),
        .memReadE_o(memReadE), .memWriteE_o(memWriteE), .pcE_o(pcE)
    );

    execMemWbStages exec0 (
        .clk(clk), .reset_i(reset_i), .rd1E_i(rd1E), .rd2E_i(rd2E), .immE_i(immE),
        .writeRegE_i(writeRegE), .aluOpE_i(aluOpE), .aluSrcImmE_i(aluSrcImmE),
        .regWriteEnE_i(regWriteEnE), .memReadE_i(memReadE), .memWriteE_i(memWriteE),
        .pcE_i(pcE), .fwdA_i(fwdA), .fwdB_i(fwdB), .stallM_i(stallM),
        .memGnt_i(memGnt), .memRdData_i(portRdData), .memReq_o(memReq),
        .memWrEn_o(memWrEn), .memAddr_o(memAddr), .memWrData_o(memWrData),
        .aluOutM_o(aluOutM), .writeRegM_o(writeRegM), .regWriteEnM_o(regWriteEnM),
        .memReadM_o(memReadM), .writeRegW_o(writeRegW_o), .regWriteEnW_o(regWriteEnW_o),
        .regWriteDataW_o(regWriteDataW_o), .pcW_o(pcW_o)
    );

    hazardUnit hazard0 (
        .rsD_i(rsD), .rtD_i(rtD), .rsE_i(rsE), .rtE_i(rtE),
        .writeRegE_i(writeRegE), .writeRegM_i(writeRegM), .writeRegW_i(writeRegW_o),
        .regWriteEnE_i(regWriteEnE), .regWriteEnM_i(regWriteEnM),
        .regWriteEnW_i(regWriteEnW_o), .memReadE_i(memReadE), .memReadM_i(memReadM),
        .branchD_i(branchD), .fetchGnt_i(fetchGnt), .loadGnt_i(loadGnt),
        .fwdA_o(fwdA), .fwdB_o(fwdB), .fwdBranchA_o(fwdBranchA),
        .fwdBranchB_o(fwdBranchB), .stallF_o(stallF), .stallD_o(stallD),
        .stallE_o(stallE), .stallM_o(stallM), .flushE_o(flushE)
    );

    memArbiter arbiter0 (
        .clk(clk), .reset_i(reset_i), .loadEn_i(loadEn_i), .loadAddr_i(loadAddr_i),
        .loadData_i(loadData_i), .memReq_i(memReq), .memWrEn_i(memWrEn),
        .memAddr_i(memAddr), .memWrData_i(memWrData), .fetchReq_i(fetchReq),
        .fetchAddr_i(fetchAddr), .loadGnt_o(loadGnt), .memGnt_o(memGnt),
        .fetchGnt_o(fetchGnt), .addr_o(portAddr), .wrEn_o(portWrEn), .wrData_o(portWrData)
    );

    unifiedMemory memory0 (
        .clk(clk), .addr_i(portAddr), .wrEn_i(portWrEn), .wrData_i(portWrData),
        .rdData_o(portRdData)
    );

endmodule

//--- bench/memArbiter_properties.sv
module memArbiterProperties (
    input logic clk,
    input logic reset_i,
    input logic loadEn_i,
    input logic memReq_i,
    input logic fetchReq_i,
    input logic loadGnt_i,
    input logic memGnt_i,
    input logic fetchGnt_i,
    input logic wrEn_i
);

    // at most one owner of the port
    grantsOneHot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0({loadGnt_i, memGnt_i, fetchGnt_i}))
        else $error("arbiter raised more than one grant");

    loadGntHasReq: assert property (@(posedge clk) disable iff (reset_i)
        loadGnt_i |-> loadEn_i)
        else $error("loader granted without a request");

    memGntHasReq: assert property (@(posedge clk) disable iff (reset_i)
        memGnt_i |-> memReq_i)
        else $error("data port granted without a request");

    fetchGntHasReq: assert property (@(posedge clk) disable iff (reset_i)
        fetchGnt_i |-> fetchReq_i)
        else $error("fetch granted without a request");

    // loader has top priority
    loaderWins: assert property (@(posedge clk) disable iff (reset_i)
        loadEn_i |-> (loadGnt_i && !memGnt_i && !fetchGnt_i))
        else $error("loader request did not win the port");

    fetchNeverWrites: assert property (@(posedge clk) disable iff (reset_i)
        fetchGnt_i |-> !wrEn_i)
        else $error("memory write enabled during a fetch grant");

endmodule

bind memArbiter memArbiterProperties arbiterProps0 (
    .clk(clk), .reset_i(reset_i), .loadEn_i(loadEn_i), .memReq_i(memReq_i),
    .fetchReq_i(fetchReq_i), .loadGnt_i(loadGnt_o), .memGnt_i(memGnt_o),
    .fetchGnt_i(fetchGnt_o), .wrEn_i(wrEn_o)
);

//--- bench/coreTb.sv
module coreTb import pipePkg::*; ();

    localparam string TESTS_PATH = "bench/pipeTests.txt";

    logic    clk;
    logic    reset;
    logic    loadEn;
    memAddrT loadAddr;
    wordT    loadData;
    wordT    pcW;
    logic    retireEn;
    regAddrT retireReg;
    wordT    retireData;

    // program image and expected retire trace
    wordT    progWords[$];
    regAddrT expRegs[$];
    wordT    expValues[$];
    wordT    expPcs[$];

    int cycleCount = 0;
    int cycleLimit = 0;
    int matched = 0;

    mipsCore dut0 (
        .clk(clk), .reset_i(reset), .loadEn_i(loadEn), .loadAddr_i(loadAddr),
        .loadData_i(loadData), .pcW_o(pcW), .regWriteEnW_o(retireEn),
        .writeRegW_o(retireReg), .regWriteDataW_o(retireData)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic checkReg(input regAddrT got, input regAddrT expected);
        if (got !== expected) begin
            abortRun($sformatf("mismatch at %0t: writeRegW_o is %0d, expected %0d",
                               $time, got, expected));
        end
    endtask

    task automatic checkData(input wordT got, input wordT expected);
        if (got !== expected) begin
            abortRun($sformatf("mismatch at %0t: regWriteDataW_o is 0x%08h, expected 0x%08h",
                               $time, got, expected));
        end
    endtask

    task automatic checkPc(input wordT got, input wordT expected);
        if (got !== expected) begin
            abortRun($sformatf("mismatch at %0t: pcW_o is 0x%08h, expected 0x%08h",
                               $time, got, expected));
        end
    endtask

    // R-type names rd, the immediate forms name rt
    function automatic regAddrT destField(input wordT word);
        if (word[31:26] == 6'h00) begin
            return word[15:11];
        end else begin
            return word[20:16];
        end
    endfunction

    // P lines carry program words and E lines the register writes in order
    task automatic readTests();
        int          fd;
        int          count;
        int          regNum;
        byte         tag;
        string       line;
        logic [31:0] value;
        fd = $fopen(TESTS_PATH, "r");
        if (fd == 0) begin
            abortRun({"could not open the test file ", TESTS_PATH});
        end else begin
            while ($fgets(line, fd) > 0) begin
                tag = line[0];
                if (tag == "P") begin
                    count = $sscanf(line, "P %h", value);
                    if (count != 1) begin
                        abortRun({"unreadable program line: ", line});
                    end else begin
                        progWords.push_back(value);
                    end
                end else if (tag == "E") begin
                    count = $sscanf(line, "E %d %h", regNum, value);
                    if (count != 2) begin
                        abortRun({"unreadable expected-write line: ", line});
                    end else begin
                        expRegs.push_back(regAddrT'(regNum));
                        expValues.push_back(value);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // each write comes from the next program word in order that names its register
    task automatic findRetirePcs();
        int searchFrom;
        int idx;
        searchFrom = 0;
        foreach (expRegs[e]) begin
            idx = searchFrom;
            while (idx < progWords.size() && destField(progWords[idx]) != expRegs[e]) begin
                idx++;
            end
            if (idx >= progWords.size()) begin
                abortRun($sformatf("no program word writes register %0d for expected entry %0d",
                                   expRegs[e], e));
            end else begin
                expPcs.push_back(wordT'(idx * PC_STEP));
                searchFrom = idx + 1;
            end
        end
    endtask

    // one word per cycle through the loader port from word 0
    task automatic loadProgram();
        for (int i = 0; i < progWords.size(); i++) begin
            loadEn   <= 1'b1;
            loadAddr <= memAddrT'(i);
            loadData <= progWords[i];
            @(posedge clk);
        end
        loadEn <= 1'b0;
    endtask

    // retire outputs are sampled at the falling edge
    task automatic waitForTrace();
        while (matched < expValues.size()) begin
            @(negedge clk);
            if (retireEn) begin
                checkReg(retireReg, expRegs[matched]);
                checkData(retireData, expValues[matched]);
                checkPc(pcW, expPcs[matched]);
                matched++;
            end
        end
    endtask

    initial begin
        reset    = 1'b1;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        readTests();
        if (progWords.size() == 0 || expValues.size() == 0) begin
            abortRun("the test file holds no program or no expected writes");
        end else begin
            findRetirePcs();
            cycleLimit = progWords.size() + 12 * expValues.size() + 40;
            repeat (2) @(posedge clk);
            reset <= 1'b0;
            loadProgram();
            waitForTrace();
            $display("TEST PASSED");
            $finish;
        end
    end

    // limit grows with the program and the trace length
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            abortRun($sformatf("the trace did not complete in %0d cycles (%0d of %0d seen)",
                               cycleLimit, matched, expValues.size()));
        end
    end

endmodule

//--- bench/pipeTests.txt
# P <instruction word, hex> [mnemonic]: program, loaded from word address 0
# E <register, decimal> <value, hex>: expected register writes in retire order
P 24010005  addiu $1, $0, 5
P 2422FFFD  addiu $2, $1, -3
P 00221821  addu  $3, $1, $2
P 00432023  subu  $4, $2, $3
P 3C051234  lui   $5, 0x1234
P 34A5ABCD  ori   $5, $5, 0xabcd
P 00A43024  and   $6, $5, $4
P 00433825  or    $7, $2, $3
P 0081402A  slt   $8, $4, $1
P 0024482A  slt   $9, $1, $4
P 240A0100  addiu $10, $0, 0x100
P AD450000  sw    $5, 0($10)
P 8D4B0000  lw    $11, 0($10)
P 256C0001  addiu $12, $11, 1
P 2400004D  addiu $0, $0, 77
P 00016821  addu  $13, $0, $1
P 240E0002  addiu $14, $0, 2
P 11C20003  beq   $14, $2, +3
P 240F0009  addiu $15, $0, 9
P 2410006F  addiu $16, $0, 111
P 241000DE  addiu $16, $0, 222
P 10220005  beq   $1, $2, +5
P 24110033  addiu $17, $0, 0x33
P 26320010  addiu $18, $17, 0x10
P 0800001C  j     0x70
P 2413FFFF  addiu $19, $0, -1
P 24140005  addiu $20, $0, 5
P 24140006  addiu $20, $0, 6
P 0261A823  subu  $21, $19, $1
P 1000FFFF  beq   $0, $0, -1
P 00000000  nop
E 1 00000005
E 2 00000002
E 3 00000007
E 4 FFFFFFFB
E 5 12340000
E 5 1234ABCD
E 6 1234ABC9
E 7 00000007
E 8 00000001
E 9 00000000
E 10 00000100
E 11 1234ABCD
E 12 1234ABCE
E 13 00000005
E 14 00000002
E 15 00000009
E 17 00000033
E 18 00000043
E 19 FFFFFFFF
E 21 FFFFFFFA

//--- src.f
design/pipePkg.sv
design/unifiedMemory.sv
design/memArbiter.sv
design/fetchStage.sv
design/decodeStage.sv
design/execMemWbStages.sv
design/hazardUnit.sv
design/mipsCore.sv
bench/memArbiter_properties.sv
bench/coreTb.sv

//--- Makefile
TOP = coreTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
